/* Makefile */
VERILATOR ?= verilator
TOP       ?= multicore_bus_wrapper_tb
OBJ_DIR   ?= obj_dir
BIN       ?= tb_sim
LOG       ?= sim.log
FLIST     ?= build.f
SRCS      := $(wildcard source/*.sv) $(wildcard verif/*.sv)
DATA      := verif/fabric_tests.dat

.PHONY: all run clean

all: run

$(OBJ_DIR)/$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(BIN)

run: $(OBJ_DIR)/$(BIN) $(DATA)
	-./$(OBJ_DIR)/$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
source/bus_types_pkg.sv
source/coherence_pkg.sv
source/fsb_arbiter.sv
source/coherence_ctrl.sv
source/l2_bus_port.sv
source/multicore_bus_wrapper.sv
verif/l2_mem_model.sv
verif/multicore_bus_wrapper_tb.sv

/* source/bus_types_pkg.sv */
package bus_types_pkg;

    // generic bus and front-side field widths
    localparam int WORD_W = 32;
    localparam int BE_W   = WORD_W / 8;

    // one data or address word
    typedef logic [WORD_W-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [BE_W-1:0] byte_en_t;

    // front-side port arrays are built in each module
    // as packed vectors of these types, one entry per port

    // l2 side view of the generic bus busy line
    typedef enum logic {
        L2_ACCESS = 1'b0,
        L2_BUSY   = 1'b1
    } l2_state_t;

endpackage

/* source/coherence_ctrl.sv */
`timescale 1ns/10ps

module coherence_ctrl
    import bus_types_pkg::*;
    import coherence_pkg::*;
#(
    parameter int NUM_HARTS = 2
) (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           grant_valid,
    input  logic [$clog2(2*NUM_HARTS)-1:0] grant_id,
    input  logic [2*NUM_HARTS-1:0]         dREN,
    input  logic [2*NUM_HARTS-1:0]         dWEN,
    input  word_t [2*NUM_HARTS-1:0]        daddr,
    input  word_t [2*NUM_HARTS-1:0]        dstore,
    input  byte_en_t [2*NUM_HARTS-1:0]     dbyte_en,
    input  logic [2*NUM_HARTS-1:0]         ccwrite,
    input  logic [2*NUM_HARTS-1:0]         ccsnoophit,
    input  logic [2*NUM_HARTS-1:0]         ccdirty,
    input  logic [2*NUM_HARTS-1:0]         ccsnoopdone,
    output logic                           grant_done,
    output logic [2*NUM_HARTS-1:0]         dwait,
    output word_t [2*NUM_HARTS-1:0]        dload,
    output logic [2*NUM_HARTS-1:0]         derror,
    output logic [2*NUM_HARTS-1:0]         ccwait,
    output logic [2*NUM_HARTS-1:0]         ccinv,
    output word_t [2*NUM_HARTS-1:0]        ccsnoopaddr,
    output logic [2*NUM_HARTS-1:0]         ccexclusive,
    output logic                           l2_start,
    output word_t                          l2_addr,
    output word_t                          l2_wdata,
    output byte_en_t                       l2_byte_en,
    output logic                           l2_write,
    input  logic                           l2_done,
    input  word_t                          l2_rdata,
    input  logic                           l2_error
);
    localparam int NPORTS = 2 * NUM_HARTS;
    localparam int ID_W   = $clog2(NPORTS);

    ctrl_state_t       state;
    ctrl_state_t       state_nxt;
    logic [NPORTS-1:0] others;
    logic [NPORTS-1:0] done_mask, hit_mask, dirty_mask;
    logic [NPORTS-1:0] done_nxt, hit_nxt, dirty_nxt;
    logic [ID_W-1:0]   dirty_id;
    logic              all_done;
    logic              snoop_txn;
    logic              supplied;
    word_t             rsp_data;
    logic              rsp_error;
    line_addr_u        req_addr;
    line_addr_u        snoop_addr;

    // snoop targets are the data ports of the other harts
    always_comb begin
        for (int i = 0; i < NPORTS; i++) begin
            others[i] = (i % 2 == 1) && (i != int'(grant_id));
        end
    end

    // only a granted data read goes through the snoop phase
    assign snoop_txn = grant_valid && grant_id[0] && dREN[grant_id] && (state != IDLE);

    // flags are sampled when each cache reports done
    assign done_nxt  = done_mask | (ccsnoopdone & others);
    assign hit_nxt   = hit_mask | (ccsnoopdone & ccsnoophit & others);
    assign dirty_nxt = dirty_mask | (ccsnoopdone & ccsnoophit & ccdirty & others);
    assign all_done  = (done_nxt & others) == others;

    // lowest dirty port supplies the line
    always_comb begin
        dirty_id = '0;
        for (int i = NPORTS - 1; i >= 0; i--) begin
            if (dirty_mask[i]) begin
                dirty_id = ID_W'(i);
            end
        end
    end

    // snoop on line address, word select and byte offset cleared
    always_comb begin
        req_addr.raw               = daddr[grant_id];
        snoop_addr                 = req_addr;
        snoop_addr.fields.word_sel = '0;
        snoop_addr.fields.byte_off = '0;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (grant_valid) begin
                    // instruction ports and writes skip the snoop
                    if (grant_id[0] && dREN[grant_id]) begin
                        state_nxt = SNOOP;
                    end else begin
                        state_nxt = L2_REQ;
                    end
                end
            end
            SNOOP: begin
                if (all_done) begin
                    state_nxt = (|dirty_nxt) ? SUPPLY_WB : L2_REQ;
                end
            end
            SUPPLY_WB: state_nxt = L2_WAIT;
            L2_REQ:    state_nxt = L2_WAIT;
            L2_WAIT: begin
                if (l2_done) begin
                    state_nxt = RESPOND;
                end
            end
            RESPOND:   state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= IDLE;
            done_mask  <= '0;
            hit_mask   <= '0;
            dirty_mask <= '0;
            supplied   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE) begin
                done_mask  <= '0;
                hit_mask   <= '0;
                dirty_mask <= '0;
                supplied   <= 1'b0;
            end else if (state == SNOOP) begin
                done_mask  <= done_nxt;
                hit_mask   <= hit_nxt;
                dirty_mask <= dirty_nxt;
            end
            if (state == SUPPLY_WB) begin
                supplied <= 1'b1;
            end
        end
    end

    // response word from the dirty cache or from l2
    always_ff @(posedge CLK) begin
        if (state == SUPPLY_WB) begin
            rsp_data <= dstore[dirty_id];
        end else if (state == L2_WAIT && l2_done && !supplied) begin
            rsp_data <= l2_rdata;
        end
        if (state == L2_WAIT && l2_done) begin
            rsp_error <= l2_error;
        end
    end

    assign grant_done = (state == RESPOND);

    // per-port response and snoop lines
    always_comb begin
        for (int i = 0; i < NPORTS; i++) begin
            dwait[i]       = !(grant_done && (i == int'(grant_id)));
            dload[i]       = rsp_data;
            derror[i]      = !dwait[i] && rsp_error;
            ccwait[i]      = snoop_txn && others[i];
            ccinv[i]       = grant_done && snoop_txn && ccwrite[grant_id] && hit_mask[i];
            ccsnoopaddr[i] = snoop_addr.raw;
            // exclusive when no other cache holds the line
            ccexclusive[i] = !dwait[i] && (hit_mask == '0);
        end
    end

    // writeback of the dirty word replaces the l2 read
    assign l2_start   = (state == SUPPLY_WB) || (state == L2_REQ);
    assign l2_addr    = daddr[grant_id];
    assign l2_write   = (state == SUPPLY_WB) || dWEN[grant_id];
    assign l2_wdata   = (state == SUPPLY_WB) ? dstore[dirty_id] : dstore[grant_id];
    assign l2_byte_en = (state == SUPPLY_WB) ? '1 : dbyte_en[grant_id];

endmodule

/* source/coherence_pkg.sv */
package coherence_pkg;

    // two words per cache line
    localparam int LINE_WORDS = 2;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);
    localparam int BYTE_OFF_W = 2;
    localparam int TAG_W      = 32 - WORD_SEL_W - BYTE_OFF_W;

    // front-side address seen as a word or as line fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [WORD_SEL_W-1:0] word_sel;
            logic [BYTE_OFF_W-1:0] byte_off;
        } fields;
    } line_addr_u;

    // transaction sequencer states
    typedef enum logic [2:0] {
        IDLE,
        SNOOP,
        SUPPLY_WB,
        L2_REQ,
        L2_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

/* source/fsb_arbiter.sv */
`timescale 1ns/10ps

module fsb_arbiter #(
    parameter int NUM_HARTS = 2
) (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic [2*NUM_HARTS-1:0]        dREN,
    input  logic [2*NUM_HARTS-1:0]        dWEN,
    input  logic                          grant_done,
    output logic                          grant_valid,
    output logic [$clog2(2*NUM_HARTS)-1:0] grant_id
);
    localparam int NPORTS = 2 * NUM_HARTS;
    localparam int ID_W   = $clog2(NPORTS);

    logic [NPORTS-1:0] req;
    logic [ID_W-1:0]   last_id;
    logic [ID_W-1:0]   pick_id;
    logic              pick_found;

    // any pending read or write counts as a request
    assign req = dREN | dWEN;

    // search starts just after the last winner
    always_comb begin
        int idx;
        pick_id    = last_id;
        pick_found = 1'b0;
        for (int k = 1; k <= NPORTS; k++) begin
            idx = (int'(last_id) + k) % NPORTS;
            if (!pick_found && req[idx]) begin
                pick_found = 1'b1;
                pick_id    = ID_W'(idx);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_id    <= '0;
            // port 0 wins first after reset
            last_id     <= ID_W'(NPORTS - 1);
        end else if (grant_valid) begin
            // grant frozen until the controller finishes
            if (grant_done) begin
                grant_valid <= 1'b0;
                last_id     <= grant_id;
            end
        end else if (pick_found) begin
            grant_valid <= 1'b1;
            grant_id    <= pick_id;
        end
    end

endmodule

/* source/l2_bus_port.sv */
`timescale 1ns/10ps

module l2_bus_port
    import bus_types_pkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    input  logic     l2_start,
    input  word_t    l2_addr,
    input  word_t    l2_wdata,
    input  byte_en_t l2_byte_en,
    input  logic     l2_write,
    output logic     l2_done,
    output word_t    l2_rdata,
    output logic     l2_error,
    output word_t    addr,
    output word_t    wdata,
    output byte_en_t byte_en,
    output logic     ren,
    output logic     wen,
    input  word_t    rdata,
    input  logic     busy,
    input  logic     error
);
    l2_state_t l2_state;
    logic      complete;

    assign l2_state = busy ? L2_BUSY : L2_ACCESS;

    // access ends on the first cycle memory is not busy
    assign complete = (ren || wen) && (l2_state == L2_ACCESS);

    always_ff @(posedge CLK) begin
        if (rst) begin
            ren     <= 1'b0;
            wen     <= 1'b0;
            l2_done <= 1'b0;
        end else begin
            l2_done <= complete;
            if (l2_start) begin
                ren <= !l2_write;
                wen <= l2_write;
            end else if (complete) begin
                ren <= 1'b0;
                wen <= 1'b0;
            end
        end
    end

    // request fields held stable through busy
    always_ff @(posedge CLK) begin
        if (l2_start) begin
            addr    <= l2_addr;
            wdata   <= l2_wdata;
            byte_en <= l2_byte_en;
        end
        if (complete) begin
            l2_rdata <= rdata;
            l2_error <= error;
        end
    end

endmodule

/* source/multicore_bus_wrapper.sv */
`timescale 1ns/10ps

module multicore_bus_wrapper
    import bus_types_pkg::*;
#(
    parameter int NUM_HARTS = 2
) (
    input  logic                       CLK,
    input  logic                       rst,
    // front-side cache ports, even instruction, odd data
    input  logic [2*NUM_HARTS-1:0]     dREN,
    input  logic [2*NUM_HARTS-1:0]     dWEN,
    input  word_t [2*NUM_HARTS-1:0]    daddr,
    input  word_t [2*NUM_HARTS-1:0]    dstore,
    input  byte_en_t [2*NUM_HARTS-1:0] dbyte_en,
    input  logic [2*NUM_HARTS-1:0]     ccwrite,
    input  logic [2*NUM_HARTS-1:0]     ccsnoophit,
    input  logic [2*NUM_HARTS-1:0]     ccdirty,
    input  logic [2*NUM_HARTS-1:0]     ccsnoopdone,
    output logic [2*NUM_HARTS-1:0]     dwait,
    output word_t [2*NUM_HARTS-1:0]    dload,
    output logic [2*NUM_HARTS-1:0]     derror,
    output logic [2*NUM_HARTS-1:0]     ccwait,
    output logic [2*NUM_HARTS-1:0]     ccinv,
    output word_t [2*NUM_HARTS-1:0]    ccsnoopaddr,
    output logic [2*NUM_HARTS-1:0]     ccexclusive,
    // generic memory bus
    output word_t                      addr,
    output word_t                      wdata,
    output byte_en_t                   byte_en,
    output logic                       ren,
    output logic                       wen,
    input  word_t                      rdata,
    input  logic                       busy,
    input  logic                       error
);
    localparam int ID_W = $clog2(2 * NUM_HARTS);

    logic            grant_valid;
    logic [ID_W-1:0] grant_id;
    logic            grant_done;
    logic            l2_start;
    word_t           l2_addr;
    word_t           l2_wdata;
    byte_en_t        l2_byte_en;
    logic            l2_write;
    logic            l2_done;
    word_t           l2_rdata;
    logic            l2_error;

    // one requester at a time
    fsb_arbiter #(
        .NUM_HARTS(NUM_HARTS)
    ) arb_i (
        .CLK(CLK),
        .rst(rst),
        .dREN(dREN),
        .dWEN(dWEN),
        .grant_done(grant_done),
        .grant_valid(grant_valid),
        .grant_id(grant_id)
    );

    coherence_ctrl #(
        .NUM_HARTS(NUM_HARTS)
    ) ctrl_i (
        .CLK(CLK),
        .rst(rst),
        .grant_valid(grant_valid),
        .grant_id(grant_id),
        .dREN(dREN),
        .dWEN(dWEN),
        .daddr(daddr),
        .dstore(dstore),
        .dbyte_en(dbyte_en),
        .ccwrite(ccwrite),
        .ccsnoophit(ccsnoophit),
        .ccdirty(ccdirty),
        .ccsnoopdone(ccsnoopdone),
        .grant_done(grant_done),
        .dwait(dwait),
        .dload(dload),
        .derror(derror),
        .ccwait(ccwait),
        .ccinv(ccinv),
        .ccsnoopaddr(ccsnoopaddr),
        .ccexclusive(ccexclusive),
        .l2_start(l2_start),
        .l2_addr(l2_addr),
        .l2_wdata(l2_wdata),
        .l2_byte_en(l2_byte_en),
        .l2_write(l2_write),
        .l2_done(l2_done),
        .l2_rdata(l2_rdata),
        .l2_error(l2_error)
    );

    // strobe side toward the held generic bus request
    l2_bus_port l2_i (
        .CLK(CLK),
        .rst(rst),
        .l2_start(l2_start),
        .l2_addr(l2_addr),
        .l2_wdata(l2_wdata),
        .l2_byte_en(l2_byte_en),
        .l2_write(l2_write),
        .l2_done(l2_done),
        .l2_rdata(l2_rdata),
        .l2_error(l2_error),
        .addr(addr),
        .wdata(wdata),
        .byte_en(byte_en),
        .ren(ren),
        .wen(wen),
        .rdata(rdata),
        .busy(busy),
        .error(error)
    );

endmodule

/* verif/fabric_tests.dat */
// op(0 rd 1 wr 2 rd excl) port addr store be hitmask dirtymask dirtydata
// exp_load exp_excl exp_inv exp_err pair_with_next
1 0 00000100 11223344 3 0 0 00000000 00000000 1 0 0 0
0 0 00000100 00000000 f 0 0 00000000 5a5a3344 1 0 0 0
1 2 00000104 cafef00d f 0 0 00000000 00000000 1 0 0 0
0 2 00000104 00000000 f 0 0 00000000 cafef00d 1 0 0 0
// data reads, no snoop hits
0 1 00000204 00000000 f 0 0 00000000 5a5ac1c7 1 0 0 0
0 3 0000030c 00000000 f 0 0 00000000 5a5ac0cf 1 0 0 0
// dirty supply then l2 readback
0 1 00000400 00000000 f 8 8 deadbeef deadbeef 0 0 0 0
0 0 00000400 00000000 f 0 0 00000000 deadbeef 1 0 0 0
0 3 00000508 00000000 f 2 2 0badc0de 0badc0de 0 0 0 0
0 2 00000508 00000000 f 0 0 00000000 0badc0de 1 0 0 0
// exclusive reads
2 1 00000600 00000000 f 8 0 00000000 5a5ac5c3 0 8 0 0
2 3 00000700 00000000 f 2 0 00000000 5a5ac4c3 0 2 0 0
2 1 00000800 00000000 f 0 0 00000000 5a5acbc3 1 0 0 0
// memory error then a clean read
0 0 f0000010 00000000 f 0 0 00000000 aa5ac3d3 1 0 1 0
0 0 00000100 00000000 f 0 0 00000000 5a5a3344 1 0 0 0
// simultaneous pairs, listed in round-robin completion order
1 2 00000900 12345678 f 0 0 00000000 00000000 1 0 0 1
0 0 00000904 00000000 f 0 0 00000000 5a5acac7 1 0 0 0
0 1 00000a00 00000000 f 0 0 00000000 5a5ac9c3 1 0 0 1
0 3 00000a04 00000000 f 0 0 00000000 5a5ac9c7 1 0 0 0
ff 0 00000000 00000000 0 0 0 00000000 00000000 0 0 0 0

/* verif/l2_mem_model.sv */
`timescale 1ns/10ps

module l2_mem_model
    import bus_types_pkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    input  word_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    input  logic     ren,
    input  logic     wen,
    output word_t    rdata,
    output logic     busy,
    output logic     error
);
    // sparse word storage, keyed by word-aligned address
    word_t mem [word_t];
    logic  started;
    int    cnt;
    word_t cur;

    // unwritten words read back a value built from the full address
    function automatic word_t read_word(input word_t a);
        word_t key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return key ^ 32'h5a5a_c3c3;
    endfunction

    // at least one busy cycle, then a random number more
    assign busy = (ren || wen) && (!started || cnt != 0);

    always_ff @(posedge CLK) begin
        if (rst) begin
            started <= 1'b0;
            cnt     <= 0;
            rdata   <= '0;
            error   <= 1'b0;
        end else if ((ren || wen) && !busy) begin
            // access completes on this edge
            started <= 1'b0;
            error   <= 1'b0;
            if (wen) begin
                cur = read_word(addr);
                for (int b = 0; b < BE_W; b++) begin
                    if (byte_en[b]) begin
                        cur[8*b +: 8] = wdata[8*b +: 8];
                    end
                end
                mem[{addr[31:2], 2'b00}] = cur;
            end
        end else if ((ren || wen) && !started) begin
            started <= 1'b1;
            cnt     <= int'($urandom % 4);
            rdata   <= read_word(addr);
            // top address nibble f is an unmapped region
            error   <= (addr[31:28] == 4'hf);
        end else if (started && cnt != 0) begin
            cnt <= cnt - 1;
        end
    end

endmodule

/* verif/multicore_bus_wrapper_tb.sv */
`timescale 1ns/10ps

module multicore_bus_wrapper_tb
    import bus_types_pkg::*;
    import coherence_pkg::*;
;
    localparam int NUM_HARTS = 2;
    localparam int NP        = 2 * NUM_HARTS;
    localparam int NF        = 13;
    localparam int MAX_LINES = 64;

    logic                CLK;
    logic                rst;
    logic [NP-1:0]       dREN, dWEN, ccwrite, ccsnoophit, ccdirty, ccsnoopdone;
    word_t [NP-1:0]      daddr, dstore;
    byte_en_t [NP-1:0]   dbyte_en;
    logic [NP-1:0]       dwait, derror, ccwait, ccinv, ccexclusive;
    word_t [NP-1:0]      dload, ccsnoopaddr;
    word_t               addr, wdata, rdata;
    byte_en_t            byte_en;
    logic                ren, wen, busy, error;

    // NF words per transaction from the tests file
    logic [31:0]   vec [0:MAX_LINES*NF-1];
    int            num_lines;
    int            cycles;
    int            limit;
    logic [NP-1:0] hit_cfg, dirty_cfg, pend_rd;
    word_t         dirty_word;
    word_t         pend_addr [NP];
    int            snoop_cnt [NP];

    multicore_bus_wrapper #(
        .NUM_HARTS(NUM_HARTS)
    ) dut_i (
        .CLK(CLK), .rst(rst),
        .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
        .dbyte_en(dbyte_en), .ccwrite(ccwrite), .ccsnoophit(ccsnoophit),
        .ccdirty(ccdirty), .ccsnoopdone(ccsnoopdone), .dwait(dwait),
        .dload(dload), .derror(derror), .ccwait(ccwait), .ccinv(ccinv),
        .ccsnoopaddr(ccsnoopaddr), .ccexclusive(ccexclusive),
        .addr(addr), .wdata(wdata), .byte_en(byte_en), .ren(ren), .wen(wen),
        .rdata(rdata), .busy(busy), .error(error)
    );

    l2_mem_model mem_i (
        .CLK(CLK), .rst(rst), .addr(addr), .wdata(wdata), .byte_en(byte_en),
        .ren(ren), .wen(wen), .rdata(rdata), .busy(busy), .error(error)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // run limit scales with the number of test lines
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout, no response from the DUT after %0d cycles", cycles);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] fld(input int idx, input int f);
        return vec[idx*NF + f];
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [NP-1:0] got,
                              input logic [NP-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_line_addr(input string name, input line_addr_u got,
                                   input line_addr_u exp);
        if (got.raw !== exp.raw) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
            stop_run();
        end
    endtask

    // other data caches answer snoops after a random delay
    task automatic serve_snoops();
        line_addr_u exp_line;
        int         src;
        for (int j = 1; j < NP; j += 2) begin
            if (ccwait[j]) begin
                src = -1;
                for (int k = 1; k < NP; k += 2) begin
                    if (k != j && pend_rd[k]) begin
                        src = k;
                    end
                end
                if (src < 0) begin
                    $display("ccwait raised on port %0d with no data read pending", j);
                    stop_run();
                end
                exp_line.raw             = pend_addr[src];
                exp_line.fields.word_sel = '0;
                exp_line.fields.byte_off = '0;
                check_line_addr("ccsnoopaddr", ccsnoopaddr[j], exp_line);
                if (!ccsnoopdone[j]) begin
                    if (snoop_cnt[j] == 0) begin
                        ccsnoopdone[j] = 1'b1;
                        ccsnoophit[j]  = hit_cfg[j];
                        ccdirty[j]     = dirty_cfg[j];
                        if (dirty_cfg[j]) begin
                            dstore[j] = dirty_word;
                        end
                    end else begin
                        snoop_cnt[j]--;
                    end
                end
            end else begin
                ccsnoopdone[j] = 1'b0;
                ccsnoophit[j]  = 1'b0;
                ccdirty[j]     = 1'b0;
                snoop_cnt[j]   = int'($urandom % 4);
            end
        end
    endtask

    task automatic issue(input int idx);
        int p;
        p           = int'(fld(idx, 1));
        daddr[p]    = fld(idx, 2);
        dstore[p]   = fld(idx, 3);
        dbyte_en[p] = byte_en_t'(fld(idx, 4));
        if (fld(idx, 0) == 1) begin
            dWEN[p] = 1'b1;
        end else begin
            dREN[p]    = 1'b1;
            ccwrite[p] = (fld(idx, 0) == 2);
            if (p % 2 == 1) begin
                pend_rd[p]   = 1'b1;
                pend_addr[p] = fld(idx, 2);
            end
        end
    endtask

    task automatic check_response(input int idx);
        int p;
        p = int'(fld(idx, 1));
        if (fld(idx, 0) != 1) begin
            check_word("dload", dload[p], fld(idx, 8));
        end
        check_flag("ccexclusive", ccexclusive[p], fld(idx, 9) != 0);
        check_mask("ccinv", ccinv, NP'(fld(idx, 10)));
        check_flag("derror", derror[p], fld(idx, 11) != 0);
        dREN[p]    = 1'b0;
        dWEN[p]    = 1'b0;
        ccwrite[p] = 1'b0;
        pend_rd[p] = 1'b0;
    endtask

    // line a must finish before line b when both are issued
    task automatic run_lines(input int a, input int b, input bit two);
        bit done_a, done_b;
        int pa;
        int pb;
        done_a     = 1'b0;
        done_b     = !two;
        pa         = int'(fld(a, 1));
        pb         = int'(fld(b, 1));
        hit_cfg    = NP'(fld(a, 5));
        dirty_cfg  = NP'(fld(a, 6));
        dirty_word = fld(a, 7);
        issue(a);
        if (two) begin
            issue(b);
        end
        while (!(done_a && done_b)) begin
            @(negedge CLK);
            serve_snoops();
            if (!done_a && !dwait[pa]) begin
                check_response(a);
                done_a = 1'b1;
            end else if (!done_b && !dwait[pb]) begin
                if (!done_a) begin
                    $display("port %0d finished before port %0d, round-robin order broken",
                             pb, pa);
                    stop_run();
                end
                check_response(b);
                done_b = 1'b1;
            end else begin
                // invalidates only come with a response
                check_mask("ccinv", ccinv, '0);
            end
        end
    endtask

    initial begin
        int idx;
        void'($urandom(32'h90b3e12f));
        cycles = 0;
        limit  = 1000;
        rst    = 1'b1;
        {dREN, dWEN, ccwrite, ccsnoophit, ccdirty, ccsnoopdone} = '0;
        daddr    = '0;
        dstore   = '0;
        dbyte_en = '0;
        pend_rd  = '0;
        for (int j = 0; j < NP; j++) begin
            snoop_cnt[j] = 0;
            pend_addr[j] = '0;
        end
        $readmemh("verif/fabric_tests.dat", vec);
        // op ff closes the list
        num_lines = 0;
        while (num_lines < MAX_LINES && fld(num_lines, 0) != 32'hff) begin
            num_lines++;
        end
        limit = 200 * num_lines;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        idx = 0;
        while (idx < num_lines) begin
            @(negedge CLK);
            if (fld(idx, 12) != 0) begin
                run_lines(idx, idx + 1, 1'b1);
                idx += 2;
            end else begin
                run_lines(idx, idx, 1'b0);
                idx++;
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule
